/* sim.f */
source/ttc_bus_pkg.sv
source/ttc_timer_pkg.sv
source/ttc_reg_if.sv
source/ttc_reg_decode.sv
source/ttc_prescaler.sv
source/ttc_counter_lite.sv
source/ttc_intr_status.sv
source/ttc_top.sv
tb/ttc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the ttc testbench with Verilator, run it into sim.log and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ttc_tb -f sim.f -o ttc_sim \
  && ./obj_dir/ttc_sim > sim.log 2>&1 \
  || { echo "Build or simulation run failed"; exit 1; }

grep -q "Test FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }

/* tb/ttc_tb.sv */
/*
  Testbench for ttc_top, host side keeps its own credit count.
  Overflow test counts down from FFFF with prescale off, about 65k cycles.
*/
`timescale 1ns/100ps
`default_nettype none

module ttc_tb
  import ttc_bus_pkg::*, ttc_timer_pkg::*;
();

  localparam int period = 20;
  // Test lengths in cycles, watchdog allows four times the sum
  localparam int len_total = 5 + 80 + 200 + 120 + 240 + 160 + 66000;
  localparam logic [data_width-1:0] intr_mask = data_width'((1 << intr_width) - 1);
  localparam logic [data_width-1:0] clk_mask  = data_width'((1 << clk_ctrl_width) - 1);

  logic                  pclk7;
  logic                  n_p_reset7;
  logic                  cmd_valid;
  cmd_op_e               cmd_op;
  logic [addr_width-1:0] cmd_addr;
  logic [data_width-1:0] cmd_wdata;
  logic                  cmd_credit;
  logic                  rsp_valid;
  logic [data_width-1:0] rsp_rdata;
  logic                  irq;

  int          sent_cnt = 0;                           // Commands issued
  int          ret_cnt;                                // Credits returned
  int          error_cnt = 0;
  int          credit_fail_cnt = 0;
  int          irq_fail_cnt = 0;
  int          check_cnt = 0;
  int          test_cnt = 0;
  int          err_start = 0;
  logic        irq_quiet = 1'b0;                       // irq must stay low
  logic [31:0] rng_state = 32'h093bfb47;

  ttc_top i_dut (
    .pclk7      (pclk7),
    .n_p_reset7 (n_p_reset7),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cmd_addr   (cmd_addr),
    .cmd_wdata  (cmd_wdata),
    .cmd_credit (cmd_credit),
    .rsp_valid  (rsp_valid),
    .rsp_rdata  (rsp_rdata),
    .irq        (irq)
  );

  initial
  begin
    pclk7 = 1'b0;
    forever #(period / 2) pclk7 = ~pclk7;
  end

  always @(posedge pclk7 or negedge n_p_reset7)
  begin
    if (!n_p_reset7)
      ret_cnt <= 0;
    else if (cmd_credit)
      ret_cnt <= ret_cnt + 1;                          // One entry freed
  end

  // Credits back never outrun commands sent, outstanding stays within the limit
  a_credit_limit: assert property (@(posedge pclk7) disable iff (!n_p_reset7)
    (ret_cnt <= sent_cnt) && ((sent_cnt - ret_cnt) <= cmd_credits))
  else
  begin
    $display("Credit count out of range, more credits returned than commands sent");
    credit_fail_cnt++;
  end

  a_irq_quiet: assert property (@(posedge pclk7) disable iff (!n_p_reset7)
    irq_quiet |-> !irq)
  else
  begin
    $display("irq went high while all enables were cleared");
    irq_fail_cnt++;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int total_errors();
    return error_cnt + credit_fail_cnt + irq_fail_cnt;
  endfunction

  // Counter control word from individual bits
  function automatic logic [data_width-1:0] ctrl_word(input logic dis, input logic intv,
                                                      input logic dec, input logic mtch,
                                                      input logic rst);
    logic [data_width-1:0] w;
    w                 = '0;
    w[ctrl_disable]   = dis;                           // Active low enable
    w[ctrl_interval]  = intv;
    w[ctrl_decrement] = dec;
    w[ctrl_match]     = mtch;
    w[ctrl_restart]   = rst;
    return w;
  endfunction

  task automatic next_cycle(input int n);
    repeat (n) @(posedge pclk7);
    #2;                                                // Drive point after the edge
  endtask

  task automatic send_cmd(input cmd_op_e op, input logic [addr_width-1:0] addr,
                          input logic [data_width-1:0] data);
    while ((sent_cnt - ret_cnt) >= cmd_credits)        // No credit left
      next_cycle(1);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_addr  = addr;
    cmd_wdata = data;
    sent_cnt++;
    next_cycle(1);
    cmd_valid = 1'b0;
  endtask

  task automatic write_reg(input logic [addr_width-1:0] addr, input logic [data_width-1:0] data);
    send_cmd(op_write, addr, data);
  endtask

  task automatic read_reg(input logic [addr_width-1:0] addr, output logic [data_width-1:0] data);
    int n;
    n = 0;
    send_cmd(op_read, addr, '0);
    while (!rsp_valid && n < 32)
    begin
      next_cycle(1);
      n++;
    end
    if (rsp_valid)
      data = rsp_rdata;                                // Stable until next edge
    else
    begin
      $display("No read response from address %0d within 32 cycles", addr);
      error_cnt++;
      data = 'x;
    end
    next_cycle(1);                                     // Leave the response cycle
  endtask

  task automatic check_value(input string name, input logic [data_width-1:0] exp,
                             input logic [data_width-1:0] act);
    check_cnt++;
    assert (act === exp)
    else
    begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      error_cnt++;
    end
  endtask

  task automatic check_at_most(input string name, input logic [data_width-1:0] limit,
                               input logic [data_width-1:0] act);
    check_cnt++;
    assert (act <= limit)
    else
    begin
      $display("Fail %s expected at most %h actual %h", name, limit, act);
      error_cnt++;
    end
  endtask

  task automatic read_check(input string name, input logic [addr_width-1:0] addr,
                            input logic [data_width-1:0] exp);
    logic [data_width-1:0] act;
    read_reg(addr, act);
    check_value(name, exp, act);
  endtask

  task automatic wait_irq(input string name, input int limit);
    int n;
    n = 0;
    while (!irq && n < limit)
    begin
      next_cycle(1);
      n++;
    end
    check_cnt++;
    assert (irq)
    else
    begin
      $display("%s: irq did not rise within %0d cycles", name, limit);
      error_cnt++;
    end
  endtask

  task automatic start_test();
    err_start = total_errors();
    test_cnt++;
  endtask

  task automatic finish_test(input string name);
    $display("%s: %s", name, (total_errors() == err_start) ? "passed" : "failed");
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial
  begin
    logic [data_width-1:0] rd;
    logic [data_width-1:0] prev;
    logic [data_width-1:0] wr_val [6];
    cmd_valid  = 1'b0;
    cmd_op     = op_read;
    cmd_addr   = '0;
    cmd_wdata  = '0;
    n_p_reset7 = 1'b0;
    repeat (5) @(posedge pclk7);
    #2;
    n_p_reset7 = 1'b1;
    next_cycle(2);

    start_test();                                      // Reset values
    irq_quiet = 1'b1;
    read_check("reset clk_ctrl", addr_clk_ctrl, data_width'(clk_ctrl_reset_value));
    read_check("reset cntr_ctrl", addr_cntr_ctrl, data_width'(ctrl_reset_value));
    read_check("reset count_val", addr_count_val, '0);
    read_check("reset interval", addr_interval, '0);
    read_check("reset match_1", addr_match_1, '0);
    read_check("reset match_2", addr_match_2, '0);
    read_check("reset match_3", addr_match_3, '0);
    read_check("reset intr_status", addr_intr_status, '0);
    read_check("reset intr_enable", addr_intr_enable, data_width'(intr_enable_reset_value));
    finish_test("reset_state");

    start_test();                                      // Register access, back to back
    for (int i = 0; i < 6; i++)
    begin
      rng_state = xorshift32(rng_state);
      wr_val[i] = rng_state[15:0];
    end
    write_reg(addr_interval, wr_val[0]);
    write_reg(addr_match_1, wr_val[1]);
    write_reg(addr_match_2, wr_val[2]);
    write_reg(addr_match_3, wr_val[3]);
    write_reg(addr_intr_enable, wr_val[4]);
    write_reg(addr_clk_ctrl, wr_val[5]);
    write_reg(4'd9, wr_val[0]);                        // Unmapped, ignored
    read_check("access interval", addr_interval, wr_val[0]);
    read_check("access match_1", addr_match_1, wr_val[1]);
    read_check("access match_2", addr_match_2, wr_val[2]);
    read_check("access match_3", addr_match_3, wr_val[3]);
    read_check("access intr_enable", addr_intr_enable, wr_val[4] & intr_mask);
    read_check("access clk_ctrl", addr_clk_ctrl, wr_val[5] & clk_mask);
    for (int a = 9; a < 16; a++)
      read_check("access unmapped", 4'(a), '0);
    next_cycle(4);
    check_value("access idle credits", data_width'(cmd_credits),
                data_width'(cmd_credits - (sent_cnt - ret_cnt)));
    write_reg(addr_clk_ctrl, '0);                      // Prescale off
    write_reg(addr_intr_enable, '0);
    finish_test("reg_access");

    start_test();                                      // Restart, counter disabled
    rng_state = xorshift32(rng_state);
    wr_val[0] = {1'b0, rng_state[14:1], 1'b1};         // Neither 0 nor FFFF
    write_reg(addr_interval, wr_val[0]);
    write_reg(addr_cntr_ctrl, ctrl_word(1'b1, 1'b1, 1'b1, 1'b0, 1'b1));
    next_cycle(4);
    read_check("restart dec interval", addr_count_val, wr_val[0]);
    read_check("restart bit cleared", addr_cntr_ctrl, ctrl_word(1'b1, 1'b1, 1'b1, 1'b0, 1'b0));
    write_reg(addr_cntr_ctrl, ctrl_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
    next_cycle(4);
    read_check("restart inc", addr_count_val, '0);
    read_check("restart bit cleared", addr_cntr_ctrl, ctrl_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    write_reg(addr_cntr_ctrl, ctrl_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b1));
    next_cycle(4);
    read_check("restart dec overflow", addr_count_val, 16'hffff);
    read_check("restart bit cleared", addr_cntr_ctrl, ctrl_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
    finish_test("restart");

    start_test();                                      // Interval 5, increment
    irq_quiet = 1'b0;
    write_reg(addr_clk_ctrl, 16'h0001);                // Prescale on, n = 0
    write_reg(addr_interval, 16'd5);
    write_reg(addr_intr_enable, data_width'(1) << intr_interval);
    write_reg(addr_cntr_ctrl, ctrl_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b1));
    next_cycle(6);                                     // Restart lands on a count_en
    for (int i = 0; i < 12; i++)
    begin
      read_reg(addr_count_val, rd);
      check_at_most("interval count_val", 16'd5, rd);
    end
    wait_irq("interval", 64);
    read_check("interval status", addr_intr_status, data_width'(1) << intr_interval);
    write_reg(addr_cntr_ctrl, ctrl_word(1'b1, 1'b1, 1'b0, 1'b0, 1'b0)); // Stop
    next_cycle(4);
    read_reg(addr_intr_status, rd);                    // Clears leftovers
    read_check("interval status cleared", addr_intr_status, '0);
    finish_test("interval_mode");

    start_test();                                      // Match 2, 3, 4 in interval 6
    write_reg(addr_intr_enable, '0);
    write_reg(addr_interval, 16'd6);
    write_reg(addr_match_1, 16'd2);
    write_reg(addr_match_2, 16'd3);
    write_reg(addr_match_3, 16'd4);
    next_cycle(3);                                     // irq register drains
    irq_quiet = 1'b1;
    write_reg(addr_cntr_ctrl, ctrl_word(1'b0, 1'b1, 1'b0, 1'b1, 1'b1));
    next_cycle(40);                                    // Several wraps at prescale 2
    write_reg(addr_cntr_ctrl, ctrl_word(1'b1, 1'b1, 1'b0, 1'b1, 1'b0));
    next_cycle(4);
    read_check("match status", addr_intr_status,
               (data_width'(1) << intr_match_1) | (data_width'(1) << intr_match_2)
               | (data_width'(1) << intr_match_3) | (data_width'(1) << intr_interval));
    irq_quiet = 1'b0;
    finish_test("match_mode");

    start_test();                                      // Overflow, decrement from FFFF
    write_reg(addr_clk_ctrl, '0);
    write_reg(addr_intr_enable, data_width'(1) << intr_overflow);
    write_reg(addr_cntr_ctrl, ctrl_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b1));
    next_cycle(4);
    read_reg(addr_count_val, prev);
    for (int i = 0; i < 8; i++)
    begin
      read_reg(addr_count_val, rd);
      check_at_most("overflow count_val", prev - 1'b1, rd); // Strictly down
      prev = rd;
    end
    wait_irq("overflow", 66000);
    read_check("overflow status", addr_intr_status, data_width'(1) << intr_overflow);
    write_reg(addr_cntr_ctrl, ctrl_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
    finish_test("overflow_decrement");

    next_cycle(4);
    $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, total_errors());
    if (total_errors() == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (len_total * 4) @(posedge pclk7);
    $display("Timeout, tests did not finish within %0d cycles", len_total * 4);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* source/ttc_top.sv */
/*
  Single channel timer subsystem with a credit based command port.
  Host starts with cmd_credits credits and must accept every response.
*/
`timescale 1ns/100ps
`default_nettype none

module ttc_top
  import ttc_bus_pkg::*, ttc_timer_pkg::*;
(
  input  wire                   pclk7,
  input  wire                   n_p_reset7,
  input  wire                   cmd_valid,
  input  cmd_op_e               cmd_op,
  input  wire [addr_width-1:0]  cmd_addr,
  input  wire [data_width-1:0]  cmd_wdata,
  output logic                  cmd_credit,
  output logic                  rsp_valid,
  output logic [data_width-1:0] rsp_rdata,
  output logic                  irq
);

  logic                  count_en;                     // Prescaler to counter
  logic [intr_width-1:0] raw_intr;                     // Counter to status

  ttc_reg_if regs ();

  ttc_reg_decode i_decode (
    .pclk7      (pclk7),
    .n_p_reset7 (n_p_reset7),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cmd_addr   (cmd_addr),
    .cmd_wdata  (cmd_wdata),
    .cmd_credit (cmd_credit),
    .rsp_valid  (rsp_valid),
    .rsp_rdata  (rsp_rdata),
    .regs       (regs.decode)
  );

  ttc_prescaler i_prescaler (
    .pclk7      (pclk7),
    .n_p_reset7 (n_p_reset7),
    .regs       (regs.prescaler),
    .count_en   (count_en)
  );

  ttc_counter_lite i_counter (
    .pclk7      (pclk7),
    .n_p_reset7 (n_p_reset7),
    .count_en   (count_en),
    .regs       (regs.counter),
    .raw_intr   (raw_intr)
  );

  ttc_intr_status i_intr (
    .pclk7      (pclk7),
    .n_p_reset7 (n_p_reset7),
    .raw_intr   (raw_intr),
    .regs       (regs.intr),
    .irq        (irq)
  );

endmodule

`default_nettype wire

/* source/ttc_intr_status.sv */
/*
  Sticky interrupt status with clear on read, enable mask and irq.
  A bit raised in the clearing cycle is kept.
*/
`timescale 1ns/100ps
`default_nettype none

module ttc_intr_status
  import ttc_timer_pkg::*;
(
  input  wire                  pclk7,
  input  wire                  n_p_reset7,
  input  wire [intr_width-1:0] raw_intr,
  ttc_reg_if.intr              regs,
  output logic                 irq
);

  logic [intr_width-1:0] status_next;

  assign status_next = (regs.status_rd ? '0 : regs.intr_status_q) | raw_intr;

  always_ff @(posedge pclk7 or negedge n_p_reset7)
  begin
    if (!n_p_reset7)
    begin
      regs.intr_status_q <= '0;
      regs.intr_enable_q <= intr_enable_reset_value;
      irq                <= 1'b0;
    end
    else
    begin
      regs.intr_status_q <= status_next;
      if (regs.intr_enable_sel)
        regs.intr_enable_q <= regs.wdata[intr_width-1:0];
      irq <= |(regs.intr_status_q & regs.intr_enable_q); // One cycle behind status
    end
  end

endmodule

`default_nettype wire

/* source/ttc_counter_lite.sv */
/*
  Timer channel counter with control, interval and match registers.
  Interval value is assumed static while counting in interval mode.
  Raw interrupts are combinational, the interrupt block registers them.
*/
`timescale 1ns/100ps
`default_nettype none

module ttc_counter_lite
  import ttc_bus_pkg::*, ttc_timer_pkg::*;
(
  input  wire                   pclk7,
  input  wire                   n_p_reset7,
  input  wire                   count_en,
  ttc_reg_if.counter            regs,
  output logic [intr_width-1:0] raw_intr
);

  logic                  counting;                     // Counted since last restart
  logic                  active;                       // Interrupts allowed
  logic                  at_zero;
  logic [data_width-1:0] wrap_top;                     // Interval value or full scale
  logic [data_width-1:0] next_count;

  // --------------------------------------------------------------------------
  // Register writes
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk7 or negedge n_p_reset7)
  begin
    if (!n_p_reset7)
    begin
      regs.cntr_ctrl_q <= ctrl_reset_value;
      regs.interval_q  <= '0;
      regs.match_1_q   <= '0;
      regs.match_2_q   <= '0;
      regs.match_3_q   <= '0;
    end
    else
    begin
      if (regs.cntr_ctrl_sel)
        regs.cntr_ctrl_q <= regs.wdata[ctrl_width-1:0];
      else if (count_en && regs.cntr_ctrl_q[ctrl_restart])
        regs.cntr_ctrl_q[ctrl_restart] <= 1'b0;        // Restart done, one count_en only

      if (regs.interval_sel)
        regs.interval_q <= regs.wdata;
      if (regs.match_1_sel)
        regs.match_1_q <= regs.wdata;
      if (regs.match_2_sel)
        regs.match_2_q <= regs.wdata;
      if (regs.match_3_sel)
        regs.match_3_q <= regs.wdata;
    end
  end

  // --------------------------------------------------------------------------
  // Count
  // --------------------------------------------------------------------------
  assign wrap_top = regs.cntr_ctrl_q[ctrl_interval] ? regs.interval_q : '1;
  assign at_zero  = (regs.count_val_q == '0);

  always_comb
  begin
    if (regs.cntr_ctrl_q[ctrl_decrement])
      next_count = at_zero ? wrap_top : regs.count_val_q - 1'b1;
    else
      next_count = (regs.count_val_q == wrap_top) ? '0 : regs.count_val_q + 1'b1;
  end

  always_ff @(posedge pclk7 or negedge n_p_reset7)
  begin
    if (!n_p_reset7)
    begin
      regs.count_val_q <= '0;
      counting         <= 1'b0;
    end
    else if (count_en)
    begin
      if (regs.cntr_ctrl_q[ctrl_restart])
      begin
        if (!regs.cntr_ctrl_q[ctrl_decrement])
          regs.count_val_q <= '0;
        else
          regs.count_val_q <= wrap_top;                // Interval value or FFFF
        counting <= 1'b0;
      end
      else if (!regs.cntr_ctrl_q[ctrl_disable])        // Enable is active low
      begin
        regs.count_val_q <= next_count;
        counting         <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Raw interrupts
  // --------------------------------------------------------------------------
  assign active = counting && !regs.cntr_ctrl_q[ctrl_restart]
                  && !regs.cntr_ctrl_q[ctrl_disable];

  assign raw_intr[intr_interval] = active && regs.cntr_ctrl_q[ctrl_interval] && at_zero;
  assign raw_intr[intr_overflow] = active && !regs.cntr_ctrl_q[ctrl_interval] && at_zero;
  assign raw_intr[intr_match_1]  = active && regs.cntr_ctrl_q[ctrl_match]
                                   && (regs.count_val_q == regs.match_1_q);
  assign raw_intr[intr_match_2]  = active && regs.cntr_ctrl_q[ctrl_match]
                                   && (regs.count_val_q == regs.match_2_q);
  assign raw_intr[intr_match_3]  = active && regs.cntr_ctrl_q[ctrl_match]
                                   && (regs.count_val_q == regs.match_3_q);

  // Increment interval count stays within the interval
  a_in_interval: assert property (@(posedge pclk7) disable iff (!n_p_reset7)
    (counting && regs.cntr_ctrl_q[ctrl_interval] && !regs.cntr_ctrl_q[ctrl_decrement]
     && !regs.cntr_ctrl_q[ctrl_disable]) |-> (regs.count_val_q <= regs.interval_q));

endmodule

`default_nettype wire

/* source/ttc_prescaler.sv */
/*
  Clock control register and prescaler.
  Disabled prescale gives count_en every cycle, else one pulse per 2^(n+1).
  count_en is registered, so it starts one cycle after reset release.
*/
`timescale 1ns/100ps
`default_nettype none

module ttc_prescaler
  import ttc_timer_pkg::*;
(
  input  wire          pclk7,
  input  wire          n_p_reset7,
  ttc_reg_if.prescaler regs,
  output logic         count_en
);

  logic [prescale_width-1:0] pre_cnt;                  // Free running
  logic [prescale_width-1:0] pre_mask;                 // Low n+1 bits set
  logic [4:0]                pre_shift;                // n+1, up to 16
  logic                      pre_wrap;

  assign pre_shift = {1'b0, regs.clk_ctrl_q[4:1]} + 5'd1;
  assign pre_mask  = (prescale_width'(1) << pre_shift) - 1'b1;
  assign pre_wrap  = ((pre_cnt & pre_mask) == pre_mask);

  always_ff @(posedge pclk7 or negedge n_p_reset7)
  begin
    if (!n_p_reset7)
      regs.clk_ctrl_q <= clk_ctrl_reset_value;
    else if (regs.clk_ctrl_sel)
      regs.clk_ctrl_q <= regs.wdata[clk_ctrl_width-1:0];
  end

  always_ff @(posedge pclk7 or negedge n_p_reset7)
  begin
    if (!n_p_reset7)
    begin
      pre_cnt  <= '0;
      count_en <= 1'b0;
    end
    else
    begin
      if (regs.clk_ctrl_sel)
        pre_cnt <= '0;                                 // New setting starts a full period
      else
        pre_cnt <= pre_cnt + 1'b1;
      count_en <= !regs.clk_ctrl_q[0] || pre_wrap;     // Bit 0 prescale enable
    end
  end

  a_en_gap: assert property (@(posedge pclk7) disable iff (!n_p_reset7)
    (regs.clk_ctrl_q[0] && count_en) |=> !count_en);

endmodule

`default_nettype wire

/* source/ttc_reg_decode.sv */
/*
  Command buffer and register decoder.
  Host must respect the credit count, there is no other back-pressure.
  Response port has no ready, rsp_valid must always be accepted.
*/
`timescale 1ns/100ps
`default_nettype none

module ttc_reg_decode
  import ttc_bus_pkg::*;
(
  input  wire                   pclk7,
  input  wire                   n_p_reset7,
  input  wire                   cmd_valid,
  input  cmd_op_e               cmd_op,
  input  wire [addr_width-1:0]  cmd_addr,
  input  wire [data_width-1:0]  cmd_wdata,
  output logic                  cmd_credit,
  output logic                  rsp_valid,
  output logic [data_width-1:0] rsp_rdata,
  ttc_reg_if.decode             regs
);

  cmd_op_e                  buf_op    [cmd_credits];   // Command buffer
  logic [addr_width-1:0]    buf_addr  [cmd_credits];
  logic [data_width-1:0]    buf_wdata [cmd_credits];
  logic [cmd_ptr_width-1:0] wr_ptr;
  logic [cmd_ptr_width-1:0] rd_ptr;
  logic [cmd_ptr_width:0]   count;                     // Entries held
  logic                     pop;
  logic                     head_write;
  reg_addr_e                head_addr;
  reg_addr_e                rd_addr;                   // Address of pending read

  assign pop        = (count != '0);                   // Oldest entry leaves every cycle
  assign cmd_credit = pop;
  assign head_addr  = reg_addr_e'(buf_addr[rd_ptr]);
  assign head_write = pop && (buf_op[rd_ptr] == op_write);

  // --------------------------------------------------------------------------
  // Buffer
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk7)
  begin
    if (cmd_valid)
    begin
      buf_op[wr_ptr]    <= cmd_op;
      buf_addr[wr_ptr]  <= cmd_addr;
      buf_wdata[wr_ptr] <= cmd_wdata;
    end
  end

  always_ff @(posedge pclk7 or negedge n_p_reset7)
  begin
    if (!n_p_reset7)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (cmd_valid)
        wr_ptr <= wr_ptr + 1'b1;                       // Wraps, depth is a power of two
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + {{cmd_ptr_width{1'b0}}, cmd_valid} - {{cmd_ptr_width{1'b0}}, pop};
    end
  end

  // --------------------------------------------------------------------------
  // Decode, one cycle after the pop
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk7 or negedge n_p_reset7)
  begin
    if (!n_p_reset7)
    begin
      regs.clk_ctrl_sel    <= 1'b0;
      regs.cntr_ctrl_sel   <= 1'b0;
      regs.interval_sel    <= 1'b0;
      regs.match_1_sel     <= 1'b0;
      regs.match_2_sel     <= 1'b0;
      regs.match_3_sel     <= 1'b0;
      regs.intr_enable_sel <= 1'b0;
      rsp_valid            <= 1'b0;
    end
    else
    begin
      regs.clk_ctrl_sel    <= head_write && (head_addr == addr_clk_ctrl);
      regs.cntr_ctrl_sel   <= head_write && (head_addr == addr_cntr_ctrl);
      regs.interval_sel    <= head_write && (head_addr == addr_interval);
      regs.match_1_sel     <= head_write && (head_addr == addr_match_1);
      regs.match_2_sel     <= head_write && (head_addr == addr_match_2);
      regs.match_3_sel     <= head_write && (head_addr == addr_match_3);
      regs.intr_enable_sel <= head_write && (head_addr == addr_intr_enable);
      rsp_valid            <= pop && !head_write;     // Read popped
    end
  end

  always_ff @(posedge pclk7)
  begin
    regs.wdata <= buf_wdata[rd_ptr];
    rd_addr    <= head_addr;
  end

  // Status clears one edge after the response cycle
  assign regs.status_rd = rsp_valid && (rd_addr == addr_intr_status);

  // Read mux on the registered address, values as seen in the response cycle
  always_comb
  begin
    case (rd_addr)
      addr_clk_ctrl:    rsp_rdata = data_width'(regs.clk_ctrl_q);
      addr_cntr_ctrl:   rsp_rdata = data_width'(regs.cntr_ctrl_q);
      addr_count_val:   rsp_rdata = regs.count_val_q;
      addr_interval:    rsp_rdata = regs.interval_q;
      addr_match_1:     rsp_rdata = regs.match_1_q;
      addr_match_2:     rsp_rdata = regs.match_2_q;
      addr_match_3:     rsp_rdata = regs.match_3_q;
      addr_intr_status: rsp_rdata = data_width'(regs.intr_status_q);
      addr_intr_enable: rsp_rdata = data_width'(regs.intr_enable_q);
      default:          rsp_rdata = '0;                // Unmapped
    endcase
  end

  // Host overran its credits
  a_no_push_full: assert property (@(posedge pclk7) disable iff (!n_p_reset7)
    !(cmd_valid && (count == cmd_credits)));

  a_one_strobe: assert property (@(posedge pclk7) disable iff (!n_p_reset7)
    $onehot0({regs.clk_ctrl_sel, regs.cntr_ctrl_sel, regs.interval_sel,
              regs.match_1_sel, regs.match_2_sel, regs.match_3_sel,
              regs.intr_enable_sel}));

endmodule

`default_nettype wire

/* source/ttc_reg_if.sv */
/*
  Register bus between the decoder and the timer blocks.
  Strobes and status_rd are single cycle pulses from the decoder.
*/
`timescale 1ns/100ps
`default_nettype none

interface ttc_reg_if
  import ttc_bus_pkg::*, ttc_timer_pkg::*;
();

  logic [data_width-1:0]     wdata;                   // Write data, valid with a strobe
  logic                      clk_ctrl_sel;
  logic                      cntr_ctrl_sel;
  logic                      interval_sel;
  logic                      match_1_sel;
  logic                      match_2_sel;
  logic                      match_3_sel;
  logic                      intr_enable_sel;
  logic                      status_rd;               // Status register read

  // Readbacks
  logic [clk_ctrl_width-1:0] clk_ctrl_q;
  logic [ctrl_width-1:0]     cntr_ctrl_q;
  logic [data_width-1:0]     interval_q;
  logic [data_width-1:0]     match_1_q;
  logic [data_width-1:0]     match_2_q;
  logic [data_width-1:0]     match_3_q;
  logic [data_width-1:0]     count_val_q;
  logic [intr_width-1:0]     intr_status_q;
  logic [intr_width-1:0]     intr_enable_q;

  modport decode (
    output wdata, clk_ctrl_sel, cntr_ctrl_sel, interval_sel, match_1_sel,
           match_2_sel, match_3_sel, intr_enable_sel, status_rd,
    input  clk_ctrl_q, cntr_ctrl_q, interval_q, match_1_q, match_2_q,
           match_3_q, count_val_q, intr_status_q, intr_enable_q
  );

  modport prescaler (input wdata, clk_ctrl_sel, output clk_ctrl_q);

  modport counter (
    input  wdata, cntr_ctrl_sel, interval_sel, match_1_sel, match_2_sel, match_3_sel,
    output cntr_ctrl_q, interval_q, match_1_q, match_2_q, match_3_q, count_val_q
  );

  modport intr (input wdata, intr_enable_sel, status_rd,
                output intr_status_q, intr_enable_q);

endinterface

`default_nettype wire

/* source/ttc_timer_pkg.sv */
/*
  Bit layout and reset values of the timer registers.
  Wave bits are stored and read back only, no waveform output exists.
*/
`default_nettype none

package ttc_timer_pkg;

  // Counter control bit positions
  typedef enum logic [2:0]
  {
    ctrl_disable   = 3'd0,                            // Counter enable, active low
    ctrl_interval  = 3'd1,                            // 1 interval, 0 overflow
    ctrl_decrement = 3'd2,
    ctrl_match     = 3'd3,
    ctrl_restart   = 3'd4,                            // Self clearing
    ctrl_wave_n    = 3'd5,
    ctrl_wave_pol  = 3'd6
  } ctrl_bit_e;

  localparam int ctrl_width = 7;
  localparam logic [ctrl_width-1:0] ctrl_reset_value = 7'b0000001; // Disabled

  // Interrupt bit positions
  typedef enum logic [2:0]
  {
    intr_interval = 3'd0,
    intr_match_1  = 3'd1,
    intr_match_2  = 3'd2,
    intr_match_3  = 3'd3,
    intr_overflow = 3'd4
  } intr_bit_e;

  localparam int intr_width = 5;
  localparam logic [intr_width-1:0] intr_enable_reset_value = '0;

  // Clock control, bit 0 prescale enable, bits 4..1 prescale value n
  localparam int clk_ctrl_width = 5;
  localparam logic [clk_ctrl_width-1:0] clk_ctrl_reset_value = '0;
  localparam int prescale_width = 17;                 // Free counter, covers n = 15

endpackage

`default_nettype wire

/* source/ttc_bus_pkg.sv */
/*
  Command port definitions and the register map of the single timer channel.
  Buffer depth equals the credit count and must stay a power of two.
*/
`default_nettype none

package ttc_bus_pkg;

  localparam int data_width    = 16;                 // Register data width
  localparam int addr_width    = 4;                  // Command address width
  localparam int cmd_credits   = 2;                  // Host credits, also buffer depth
  localparam int cmd_ptr_width = $clog2(cmd_credits);

  typedef enum logic
  {
    op_read,
    op_write
  } cmd_op_e;

  // Register map, other addresses read 0 and ignore writes
  typedef enum logic [addr_width-1:0]
  {
    addr_clk_ctrl    = 4'd0,
    addr_cntr_ctrl   = 4'd1,
    addr_count_val   = 4'd2,                          // Read only
    addr_interval    = 4'd3,
    addr_match_1     = 4'd4,
    addr_match_2     = 4'd5,
    addr_match_3     = 4'd6,
    addr_intr_status = 4'd7,                          // Read only, clears on read
    addr_intr_enable = 4'd8
  } reg_addr_e;

endpackage

`default_nettype wire
